//--- denseClassifier.f
+incdir+verification
source/nnConfigPkg.sv
source/nnWeightsPkg.sv
source/neuronBank.sv
source/outputClassifier.sv
source/denseClassifier.sv
verification/denseClassifierTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the classifier testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

buildDir=build
logFile=sim.log

verilator --binary --assert -Wno-fatal --top-module denseClassifierTb \
	-f denseClassifier.f --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

grep -q "^TESTBENCH PASSED$" "$logFile"
if [ $? -ne 0 ]; then
	echo "Pass message not found in $logFile"
	exit 1
fi
exit 0

//--- source/denseClassifier.sv
`timescale 1ns/1ps

module denseClassifier
	import nnConfigPkg::*;
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              inValid,
	input  logic [NumInputs*ActWidth-1:0]     inVector,
	output logic                              outValid,
	output logic [ClassIdxWidth-1:0]          classIndex,
	output logic signed [AccWidth-1:0]        classScore
);

	logic hiddenValid;
	logic [NeuronsPerBank*ActWidth-1:0] bankAct0;
	logic [NeuronsPerBank*ActWidth-1:0] bankAct1;
	logic [NumHidden*ActWidth-1:0] hiddenAct;

	// Bank 0 supplies the lower hidden neurons.
	assign hiddenAct = {bankAct1, bankAct0};

	neuronBank #(
		.FirstNeuron(0)
	) bank0 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.hiddenValid(hiddenValid),
		.hiddenAct(bankAct0)
	);

	// Same timing as bank 0, so its strobe is not needed.
	neuronBank #(
		.FirstNeuron(NeuronsPerBank)
	) bank1 (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.hiddenValid(),
		.hiddenAct(bankAct1)
	);

	outputClassifier classifier (
		.clk(clk),
		.reset(reset),
		.hiddenValid(hiddenValid),
		.hiddenAct(hiddenAct),
		.outValid(outValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

//--- source/neuronBank.sv
`timescale 1ns/1ps

module neuronBank
	import nnConfigPkg::*;
	import nnWeightsPkg::*;
#(
	parameter int FirstNeuron = 0
)
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 inValid,
	input  logic [NumInputs*ActWidth-1:0]        inVector,
	output logic                                 hiddenValid,
	output logic [NeuronsPerBank*ActWidth-1:0]   hiddenAct
);

	logic signed [ActWidth-1:0] actReg [NumInputs];
	logic inValidReg;

	logic signed [AccWidth-1:0] sumNext [NeuronsPerBank];
	logic signed [AccWidth-1:0] sumReg [NeuronsPerBank];
	logic sumValid;

	// ReLU on the true sign bit, then clip to the activation ceiling.
	function automatic logic [ActWidth-1:0] clipRelu(input logic signed [AccWidth-1:0] sum);
		if (sum[AccWidth-1])
			return '0;
		else if (sum > AccWidth'(ActMax))
			return ActWidth'(ActMax);
		else
			return sum[ActWidth-1:0];
	endfunction

	// Stage 1 captures the input vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValidReg <= 1'b0;
			for (int i = 0; i < NumInputs; i++)
				actReg[i] <= '0;
		end
		else
		begin
			inValidReg <= inValid;
			for (int i = 0; i < NumInputs; i++)
				actReg[i] <= inVector[i*ActWidth +: ActWidth];
		end
	end

	// Signed products are formed at accumulator width.
	always_comb
	begin
		for (int n = 0; n < NeuronsPerBank; n++)
		begin
			sumNext[n] = AccWidth'(HiddenBias[FirstNeuron + n]);
			for (int i = 0; i < NumInputs; i++)
				sumNext[n] = sumNext[n] + actReg[i] * HiddenWeights[FirstNeuron + n][i];
		end
	end

	// Stage 2 holds the weighted sums.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumValid <= 1'b0;
			for (int n = 0; n < NeuronsPerBank; n++)
				sumReg[n] <= '0;
		end
		else
		begin
			sumValid <= inValidReg;
			for (int n = 0; n < NeuronsPerBank; n++)
				sumReg[n] <= sumNext[n];
		end
	end

	// Stage 3 holds the clipped activations.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hiddenValid <= 1'b0;
			hiddenAct <= '0;
		end
		else
		begin
			hiddenValid <= sumValid;
			for (int n = 0; n < NeuronsPerBank; n++)
				hiddenAct[n*ActWidth +: ActWidth] <= clipRelu(sumReg[n]);
		end
	end

	hiddenValidKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(hiddenValid))
		else $error("neuronBank %0d: hiddenValid is unknown", FirstNeuron);

	for (genvar n = 0; n < NeuronsPerBank; n++)
	begin : clipCheck
		actWithinCeiling: assert property (@(posedge clk) disable iff (reset)
			hiddenValid |-> (hiddenAct[n*ActWidth +: ActWidth] <= ActMax))
			else $error("neuron %0d activation above ceiling", FirstNeuron + n);
	end

endmodule

//--- source/nnConfigPkg.sv
package nnConfigPkg;

	// Network shape.
	localparam int NumInputs = 15;
	localparam int NumHidden = 4;
	localparam int NeuronsPerBank = 2;
	localparam int NumClasses = 3;

	// Activations and weights share one signed byte width.
	localparam int ActWidth = 8;

	// Wide enough for 15 full-scale products plus bias without overflow.
	localparam int AccWidth = 20;

	// Hidden activations are clipped to this ceiling after ReLU.
	localparam int ActMax = 127;

	localparam int ClassIdxWidth = 2;

	// Input strobe to output pulse.
	// Three stages in the neuron banks, two in the classifier.
	localparam int Latency = 5;

endpackage

//--- source/nnWeightsPkg.sv
package nnWeightsPkg;

	import nnConfigPkg::*;

	// Hidden layer, one row per neuron, one column per input activation.
	localparam logic signed [ActWidth-1:0] HiddenWeights [NumHidden][NumInputs] = '{
		'{
			8'sd54, -8'sd12, 8'sd31, 8'sd7, -8'sd45,
			8'sd22, 8'sd68, -8'sd9, 8'sd15, -8'sd33,
			8'sd40, 8'sd3, -8'sd27, 8'sd11, 8'sd19
		},
		'{
			-8'sd20, 8'sd47, -8'sd8, 8'sd36, 8'sd12,
			-8'sd51, 8'sd5, 8'sd29, -8'sd16, 8'sd44,
			-8'sd7, 8'sd58, 8'sd21, -8'sd38, 8'sd9
		},
		'{
			8'sd13, 8'sd25, -8'sd42, -8'sd17, 8'sd60,
			8'sd8, -8'sd30, 8'sd49, 8'sd35, -8'sd6,
			8'sd18, -8'sd24, 8'sd52, 8'sd27, -8'sd11
		},
		'{
			-8'sd37, 8'sd6, 8'sd28, 8'sd55, -8'sd14,
			8'sd39, -8'sd22, -8'sd3, 8'sd48, 8'sd16,
			-8'sd59, 8'sd10, 8'sd33, -8'sd26, 8'sd41
		}
	};

	// Neuron 1 has a negative bias, so an all-zero input leaves it at zero.
	localparam logic signed [ActWidth-1:0] HiddenBias [NumHidden] = '{
		8'sd12,
		-8'sd20,
		8'sd5,
		8'sd30
	};

	// Output layer, one row per class, one column per hidden neuron.
	localparam logic signed [ActWidth-1:0] OutputWeights [NumClasses][NumHidden] = '{
		'{8'sd45, -8'sd20, 8'sd10, -8'sd15},
		'{-8'sd12, 8'sd38, -8'sd25, 8'sd18},
		'{8'sd8, -8'sd14, 8'sd41, 8'sd22}
	};

	localparam logic signed [ActWidth-1:0] OutputBias [NumClasses] = '{
		8'sd4,
		-8'sd6,
		8'sd2
	};

endpackage

//--- source/outputClassifier.sv
`timescale 1ns/1ps

module outputClassifier
	import nnConfigPkg::*;
	import nnWeightsPkg::*;
(
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              hiddenValid,
	input  logic [NumHidden*ActWidth-1:0]     hiddenAct,
	output logic                              outValid,
	output logic [ClassIdxWidth-1:0]          classIndex,
	output logic signed [AccWidth-1:0]        classScore
);

	logic signed [AccWidth-1:0] scoreNext [NumClasses];
	logic signed [AccWidth-1:0] scoreReg [NumClasses];
	logic scoreValid;

	logic [ClassIdxWidth-1:0] bestIdx;
	logic signed [AccWidth-1:0] bestScore;

	// Hidden activations are unsigned, so a zero bit is prepended before the signed multiply.
	always_comb
	begin
		for (int c = 0; c < NumClasses; c++)
		begin
			scoreNext[c] = AccWidth'(OutputBias[c]);
			for (int h = 0; h < NumHidden; h++)
				scoreNext[c] = scoreNext[c]
					+ $signed({1'b0, hiddenAct[h*ActWidth +: ActWidth]}) * OutputWeights[c][h];
		end
	end

	// Stage 4 holds the class scores.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scoreValid <= 1'b0;
			for (int c = 0; c < NumClasses; c++)
				scoreReg[c] <= '0;
		end
		else
		begin
			scoreValid <= hiddenValid;
			for (int c = 0; c < NumClasses; c++)
				scoreReg[c] <= scoreNext[c];
		end
	end

	// Strict compare keeps the lowest index on a tie.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scoreReg[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (scoreReg[c] > bestScore)
			begin
				bestIdx = ClassIdxWidth'(c);
				bestScore = scoreReg[c];
			end
		end
	end

	// Stage 5 holds the winner.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			outValid <= scoreValid;
			classIndex <= bestIdx;
			classScore <= bestScore;
		end
	end

	classIndexInRange: assert property (@(posedge clk) disable iff (reset)
		outValid |-> (classIndex < NumClasses))
		else $error("classIndex %0d out of range", classIndex);

	// Every hidden strobe yields one output pulse two cycles on, and no pulse comes from elsewhere.
	pulseFollowsHidden: assert property (@(posedge clk) disable iff (reset)
		hiddenValid |-> ##2 outValid)
		else $error("outValid missing two cycles after hiddenValid");

	pulseHasSource: assert property (@(posedge clk) disable iff (reset)
		outValid |-> $past(hiddenValid, 2))
		else $error("outValid without hiddenValid two cycles earlier");

endmodule

//--- verification/classifierModel.svh
`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// Weighted sum plus bias, ReLU on the sign, then the clip ceiling.
function automatic int hiddenActivation(input int neuron,
	input logic [NumInputs*ActWidth-1:0] vec);
	int sum;
	sum = int'(HiddenBias[neuron]);
	for (int i = 0; i < NumInputs; i++)
		sum += int'($signed(vec[i*ActWidth +: ActWidth])) * int'(HiddenWeights[neuron][i]);
	if (sum < 0)
		return 0;
	else if (sum > ActMax)
		return ActMax;
	return sum;
endfunction

// Hidden activations are non-negative here, so no sign handling is needed.
function automatic int classScoreFor(input int cls,
	input logic [NumInputs*ActWidth-1:0] vec);
	int score;
	score = int'(OutputBias[cls]);
	for (int h = 0; h < NumHidden; h++)
		score += hiddenActivation(h, vec) * int'(OutputWeights[cls][h]);
	return score;
endfunction

// Highest score wins; on a tie the lowest class index is kept.
function automatic void predictClass(input logic [NumInputs*ActWidth-1:0] vec,
	output int bestIdx, output int bestScore);
	int score;
	bestIdx = 0;
	bestScore = classScoreFor(0, vec);
	for (int c = 1; c < NumClasses; c++)
	begin
		score = classScoreFor(c, vec);
		if (score > bestScore)
		begin
			bestIdx = c;
			bestScore = score;
		end
	end
endfunction

`endif

//--- verification/denseClassifierTb.sv
`timescale 1ns/1ps

module denseClassifierTb
	import nnConfigPkg::*;
	import nnWeightsPkg::*;
();

	localparam int ClockPeriod = 4;
	localparam int ResetCycles = 5;
	localparam int MaxGap = 3;
	localparam int RandomVectors = 200;
	// Zero, favorites, extremes, back to back, reset stream and random vectors.
	localparam int TotalVectors = 1 + NumClasses + 3 + 12 + 12 + RandomVectors;
	localparam int MarginCycles = 300;
	localparam int WatchdogCycles = TotalVectors * (MaxGap + 1) + Latency + MarginCycles;

	logic clk = 1'b0;
	logic reset;
	logic inValid;
	logic [NumInputs*ActWidth-1:0] inVector;
	logic outValid;
	logic [ClassIdxWidth-1:0] classIndex;
	logic signed [AccWidth-1:0] classScore;

	int cycle = 0;
	logic resetSeen = 1'b1;
	int expCycle [$];
	int expIndex [$];
	int expScore [$];
	int checkCount = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	integer seed = 8713;

	`include "classifierModel.svh"

	denseClassifier DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.outValid(outValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	initial
	begin
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// Cycle count and reset as the DUT saw them at the last rising edge.
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		resetSeen <= reset;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			valueErrors++;
			$display("FAILED %s: actual 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they settle.
	always @(negedge clk)
	begin
		if (resetSeen)
		begin
			checkValue("outValid", 32'(outValid), 32'd0);
			expCycle.delete();
			expIndex.delete();
			expScore.delete();
		end
		else if (outValid)
		begin
			if (expCycle.size() == 0 || expCycle[0] != cycle)
			begin
				otherErrors++;
				$display("Unexpected outValid pulse at cycle %0d", cycle);
			end
			else
			begin
				checkValue("classIndex", 32'(classIndex), 32'(expIndex[0]));
				checkValue("classScore", 32'(classScore), 32'(expScore[0]));
				void'(expCycle.pop_front());
				void'(expIndex.pop_front());
				void'(expScore.pop_front());
			end
		end
		else if (expCycle.size() > 0 && expCycle[0] <= cycle)
		begin
			otherErrors++;
			$display("Missing outValid pulse that was due at cycle %0d", expCycle[0]);
			void'(expCycle.pop_front());
			void'(expIndex.pop_front());
			void'(expScore.pop_front());
		end
	end

	task automatic driveVector(input logic [NumInputs*ActWidth-1:0] vec);
		int idx;
		int score;
		@(negedge clk);
		inValid = 1'b1;
		inVector = vec;
		predictClass(vec, idx, score);
		expCycle.push_back(cycle + Latency);
		expIndex.push_back(idx);
		expScore.push_back(score);
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	task automatic applyReset(input int count);
		reset = 1'b1;
		inValid = 1'b0;
		repeat (count) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic drainOutputs();
		int waited;
		waited = 0;
		idleCycles(1);
		while (expCycle.size() > 0 && waited < Latency + 2)
		begin
			idleCycles(1);
			waited++;
		end
		if (expCycle.size() > 0)
		begin
			otherErrors++;
			$display("Gave up waiting for %0d pending outputs", expCycle.size());
			expCycle.delete();
			expIndex.delete();
			expScore.delete();
		end
		idleCycles(2);
	endtask

	// With no input, each hidden neuron holds the ReLU of its bias.
	task automatic zeroInput();
		int waited;
		int expected;
		waited = 0;
		driveVector('0);
		idleCycles(1);
		while (!DUT.hiddenValid && waited < Latency)
		begin
			idleCycles(1);
			waited++;
		end
		if (!DUT.hiddenValid)
		begin
			otherErrors++;
			$display("hiddenValid never rose for the all-zero vector");
		end
		else
		begin
			for (int n = 0; n < NumHidden; n++)
			begin
				expected = (HiddenBias[n] < 0) ? 0 : int'(HiddenBias[n]);
				checkValue($sformatf("hiddenAct[%0d]", n),
					32'(DUT.hiddenAct[n*ActWidth +: ActWidth]), 32'(expected));
			end
		end
		drainOutputs();
	endtask

	// A single small input that lifts mostly one hidden neuron.
	task automatic classFavorites();
		int favorInput [NumClasses] = '{0, 11, 4};
		logic [NumInputs*ActWidth-1:0] vec;
		for (int c = 0; c < NumClasses; c++)
		begin
			vec = '0;
			vec[favorInput[c]*ActWidth +: ActWidth] = 8'sd2;
			driveVector(vec);
			idleCycles(Latency);
			checkValue("classIndex", 32'(classIndex), 32'(c));
		end
		drainOutputs();
	endtask

	task automatic extremeInputs();
		logic [NumInputs*ActWidth-1:0] vec;
		driveVector({NumInputs{8'h7f}});
		driveVector({NumInputs{8'h80}});
		for (int i = 0; i < NumInputs; i++)
			vec[i*ActWidth +: ActWidth] = (i % 2 == 0) ? 8'h7f : 8'h80;
		driveVector(vec);
		drainOutputs();
	endtask

	task automatic randomVector(output logic [NumInputs*ActWidth-1:0] vec);
		for (int i = 0; i < NumInputs; i++)
			vec[i*ActWidth +: ActWidth] = 8'($random(seed));
	endtask

	task automatic backToBack();
		logic [NumInputs*ActWidth-1:0] vec;
		repeat (12)
		begin
			randomVector(vec);
			driveVector(vec);
		end
		drainOutputs();
	endtask

	// Some results leave before the reset, the rest are flushed.
	task automatic resetMidStream();
		logic [NumInputs*ActWidth-1:0] vec;
		repeat (8)
		begin
			randomVector(vec);
			driveVector(vec);
		end
		@(negedge clk);
		applyReset(2);
		repeat (4)
		begin
			randomVector(vec);
			driveVector(vec);
		end
		drainOutputs();
	endtask

	task automatic randomTraffic();
		logic [NumInputs*ActWidth-1:0] vec;
		int gap;
		for (int v = 0; v < RandomVectors; v++)
		begin
			randomVector(vec);
			driveVector(vec);
			gap = int'($unsigned($random(seed)) % (MaxGap + 1));
			idleCycles(gap);
		end
		drainOutputs();
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inVector = '0;
		applyReset(ResetCycles);
		zeroInput();
		classFavorites();
		extremeInputs();
		backToBack();
		resetMidStream();
		randomTraffic();
		$display("Checks: %0d, value mismatches: %0d, other errors: %0d",
			checkCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("Watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
